// ==== bench/rv_core_input.hex ====
// Words 000-07F program and data image, word 080 is the load source
// From word 100 on: store records as address, data, select, closed by FFFFFFFF
30000513
FFB00093
00700113
401101B3
00352023
0020A233
0020B2B3
00452223
00552423
4010D313
00411393
00652623
00752823
12345437
00001497
00852A23
00952C23
20000593
00158603
0025D683
00C52E23
02D52023
021502A3
02251323
02452703
02651783
02E52423
02554803
010788B3
03152623
00210463
100A0A13
00208463
001A0A13
00209463
100A0A13
00211463
001A0A13
0020C463
100A0A13
0011C463
001A0A13
0011D463
100A0A13
0020D463
001A0A13
0011E463
100A0A13
0020E463
001A0A13
0020F463
100A0A13
0011F463
001A0A13
03452823
00800AEF
100A0A13
00000B17
011B0BE7
100A0A13
100A0A13
03552A23
03752C23
05500013
02052E23
05452023
0000006F
@80
8765A5C3
@100
00000300 0000000C 0000000F
00000304 00000001 0000000F
00000308 00000000 0000000F
0000030C FFFFFFFD 0000000F
00000310 00000070 0000000F
00000314 12345000 0000000F
00000318 00001038 0000000F
0000031C FFFFFFA5 0000000F
00000320 00008765 0000000F
00000325 FBFBFBFB 00000002
00000326 00070007 0000000C
00000328 0007FB00 0000000F
0000032C 00000102 0000000F
00000330 00000006 0000000F
00000334 000000E0 0000000F
00000338 000000EC 0000000F
0000033C 00000000 0000000F
00000340 00000006 0000000F
FFFFFFFF

// ==== verilog.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regs.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_core.sv
bench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f verilog.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;

    import rv_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int FILE_WORDS = 512;
    localparam int REC_BASE   = 256;    // Store records start here in the file image
    localparam int PROG_WORDS = 128;

    logic        clk;
    logic        reset_n;
    logic        reset_q;           // reset_n as seen at the last rising edge
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic [31:0] wb_rdata;
    logic        ack;

    logic [31:0] file_mem [FILE_WORDS];
    logic [31:0] mem [256];
    bus_req_t    exp_rec [$];
    int          n_rec;
    int          rec_idx;
    int          n_words;
    int          value_errors;
    int          other_errors;

    logic [15:0] lfsr;
    bus_req_t    held;
    logic        busy;
    int          wait_cnt;
    logic        expect_data;       // Next transfer is the data access of a load or store
    logic        fetch_known;
    logic [31:0] exp_fetch;
    logic        fetch_alt;         // Branch, so the target is also a legal next fetch
    logic [31:0] alt_fetch;

    rv_core dut_i (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .o_wb_adr  (wb_adr),
        .o_wb_dat  (wb_dat),
        .o_wb_sel  (wb_sel),
        .o_wb_we   (wb_we),
        .o_wb_stb  (wb_stb),
        .o_wb_cyc  (wb_cyc),
        .i_wb_dat  (wb_rdata),
        .i_wb_ack  (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        reset_q <= reset_n;

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // B-type immediate as laid out in the instruction word
    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // J-type immediate
    function automatic logic [31:0] jump_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic take_wait_count(output int n);
        n = 0;
        for (int i = 0; i < 2; i++)
        begin
            n = (n << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_req(input string name, input bus_req_t got, input bus_req_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("CHECK FAILED %s: adr=%h dat=%h sel=%h we=%h", name,
                     got.adr, got.dat, got.sel, got.we);
            $display("    expected adr=%h dat=%h sel=%h we=%h",
                     exp.adr, exp.dat, exp.sel, exp.we);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic begin_transfer(input bus_req_t r);
        if (!expect_data)
        begin
            if (!fetch_known)
                exp_fetch = r.adr;          // JALR target depends on a register
            else
            begin
                if (fetch_alt && r.adr === alt_fetch)
                    exp_fetch = alt_fetch;  // Branch taken
                check_word("fetch o_wb_adr", r.adr, exp_fetch);
            end
            check_word("fetch {o_wb_sel,o_wb_we}", {27'd0, r.sel, r.we}, {27'd0, 4'hf, 1'b0});
        end
    endtask

    task automatic end_transfer(input bus_req_t r);
        logic [6:0] opcode;
        if (r.we)
        begin
            if (!expect_data)
            begin
                other_errors++;
                $display("Write seen where an instruction fetch was expected at %h", r.adr);
            end
            for (int b = 0; b < 4; b++)
                if (r.sel[b])
                    mem[r.adr[9:2]][8*b +: 8] = r.dat[8*b +: 8];
            if (rec_idx >= n_rec)
            begin
                other_errors++;
                $display("Extra store beyond the expected list: adr %h dat %h", r.adr, r.dat);
            end
            else
                check_req("store o_wb_*", r, exp_rec[rec_idx]);
            rec_idx++;
        end
        wb_rdata = mem[r.adr[9:2]];
        if (expect_data)
            expect_data = 1'b0;
        else
        begin
            opcode      = wb_rdata[6:0];
            expect_data = (opcode == `RV_OP_LOAD) || (opcode == `RV_OP_STORE);
            fetch_known = (opcode != `RV_OP_JALR);
            fetch_alt   = (opcode == `RV_OP_BRANCH);
            alt_fetch   = exp_fetch + branch_offset(wb_rdata);
            if (opcode == `RV_OP_JAL)
                exp_fetch = exp_fetch + jump_offset(wb_rdata);
            else
                exp_fetch = exp_fetch + 32'd4;
        end
    endtask

    // Bus memory model, answers after 0 to 3 wait cycles
    always @(negedge clk)
    begin
        bus_req_t cur;
        cur = '{adr: wb_adr, dat: wb_dat, sel: wb_sel, we: wb_we};
        if (!reset_q)
        begin
            ack  = 1'b0;
            busy = 1'b0;
            if (wb_stb || wb_cyc || wb_we)
            begin
                other_errors++;
                $display("Bus strobe, cycle or write active during or right after reset");
            end
        end
        else if (ack)
            ack = 1'b0;
        else if (wb_stb)
        begin
            if (!wb_cyc)
            begin
                other_errors++;
                $display("o_wb_cyc low while o_wb_stb is high at %h", wb_adr);
            end
            if (!busy)
            begin
                busy = 1'b1;
                held = cur;
                take_wait_count(wait_cnt);
                begin_transfer(cur);
            end
            else
                check_req("held o_wb_*", cur, held);
            if (wait_cnt == 0)
            begin
                end_transfer(cur);
                ack  = 1'b1;
                busy = 1'b0;
            end
            else
                wait_cnt--;
        end
        else if (busy)
        begin
            other_errors++;
            busy = 1'b0;
            $display("o_wb_stb dropped before the transfer was acknowledged");
        end
    end

    initial
    begin
        #1;
        #(64 * 4 * n_words * CLK_PERIOD);
        $display("Timeout after %0d cycles. Errors: %0d value, %0d other; stores %0d of %0d",
                 64 * 4 * n_words, value_errors, other_errors, rec_idx, n_rec);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        int       i;
        bus_req_t rec;
        reset_n      = 1'b0;
        ack          = 1'b0;
        wb_rdata     = '0;
        lfsr         = 16'd49851;
        busy         = 1'b0;
        wait_cnt     = 0;
        expect_data  = 1'b0;
        fetch_known  = 1'b1;
        exp_fetch    = `RV_RESET_ADDR;
        fetch_alt    = 1'b0;
        alt_fetch    = '0;
        rec_idx      = 0;
        value_errors = 0;
        other_errors = 0;
        n_words      = 0;
        for (i = 0; i < FILE_WORDS; i++)
            file_mem[i] = '0;
        $readmemh("bench/rv_core_input.hex", file_mem);
        for (i = 0; i < 256; i++)
            mem[i] = file_mem[i];
        for (i = 0; i < PROG_WORDS; i++)
            if (file_mem[i] != 32'd0)
                n_words = i + 1;
        i = REC_BASE;
        while (i + 2 < FILE_WORDS && file_mem[i] != 32'hFFFF_FFFF)
        begin
            rec.adr = file_mem[i];
            rec.dat = file_mem[i+1];
            rec.sel = file_mem[i+2][3:0];
            rec.we  = 1'b1;
            exp_rec.push_back(rec);
            i += 3;
        end
        n_rec = exp_rec.size();

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        wait (rec_idx >= n_rec);
        repeat (40) @(negedge clk);     // Window for any extra store
        $display("Errors: %0d value, %0d other; stores %0d of %0d",
                 value_errors, other_errors, rec_idx, n_rec);
        if (value_errors == 0 && other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module rv_core
#(
    parameter logic [31:0] RESET_ADDR = `RV_RESET_ADDR
)
(
    input  wire         i_clk,
    input  wire         i_reset_n,
    output logic [31:0] o_wb_adr,
    output logic [31:0] o_wb_dat,
    output logic [3:0]  o_wb_sel,
    output logic        o_wb_we,
    output logic        o_wb_stb,
    output logic        o_wb_cyc,
    input  wire  [31:0] i_wb_dat,
    input  wire         i_wb_ack
);

    import rv_pkg::*;

    typedef enum logic [2:0] {
        st_start, st_fetch, st_decode, st_exec, st_mem, st_wb
    } state_e;

    state_e      state, state_nxt;
    bus_req_t    fetch_req, lsu_req, req;
    instr_u      instr;
    decode_t     dec, dec_q;
    exec_t       exec, exec_q;
    logic [31:0] pc;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] wb_data;
    logic        lsu_done;

    always_comb
    begin
        case (state)
            st_start:  state_nxt = st_fetch;      // Bus idle one cycle after reset
            st_fetch:  state_nxt = i_wb_ack ? st_decode : st_fetch;
            st_decode: state_nxt = st_exec;
            st_exec:   state_nxt = st_mem;
            st_mem:    state_nxt = lsu_done ? st_wb : st_mem;
            st_wb:     state_nxt = st_fetch;
            default:   state_nxt = st_start;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= st_start;
        else
            state <= state_nxt;
    end

    always_ff @(posedge i_clk)
    begin
        if (state == st_decode)
            dec_q <= dec;
        if (state == st_exec)
            exec_q <= exec;
    end

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) fetch_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_fetch   (state == st_fetch),
        .i_ack     (i_wb_ack),
        .i_rdata   (i_wb_dat),
        .i_advance (state == st_wb),
        .i_exec    (exec_q),
        .o_req     (fetch_req),
        .o_pc      (pc),
        .o_instr   (instr)
    );

    rv_decode decode_i (
        .i_instr (instr),
        .i_pc    (pc),
        .o_dec   (dec)
    );

    rv_regs regs_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rs1     (dec.rs1),
        .i_rs2     (dec.rs2),
        .i_rd      (dec_q.rd),
        .i_write   ((state == st_wb) && dec_q.reg_write),
        .i_data    (wb_data),
        .o_data1   (rs1_data),
        .o_data2   (rs2_data)
    );

    rv_execute execute_i (
        .i_dec      (dec_q),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_exec     (exec)
    );

    rv_lsu lsu_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_mem     (state == st_mem),
        .i_dec     (dec_q),
        .i_exec    (exec_q),
        .i_pc      (pc),
        .i_ack     (i_wb_ack),
        .i_rdata   (i_wb_dat),
        .o_req     (lsu_req),
        .o_wb_data (wb_data),
        .o_done    (lsu_done)
    );

    // Data access owns the bus only in MEM
    assign req = (state == st_mem) ? lsu_req : fetch_req;

    assign o_wb_stb = (state == st_fetch) ||
                      ((state == st_mem) && (dec_q.is_load || dec_q.is_store));
    assign o_wb_cyc = o_wb_stb;
    assign o_wb_adr = req.adr;
    assign o_wb_dat = req.dat;
    assign o_wb_sel = req.sel;
    assign o_wb_we  = o_wb_stb & req.we;

endmodule

`default_nettype wire

// ==== hw/rv_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_lsu
(
    input  wire                   i_clk,
    input  wire                   i_reset_n,
    input  wire                   i_mem,
    input  wire  rv_pkg::decode_t i_dec,
    input  wire  rv_pkg::exec_t   i_exec,
    input  wire  [31:0]           i_pc,
    input  wire                   i_ack,
    input  wire  [31:0]           i_rdata,
    output rv_pkg::bus_req_t      o_req,
    output logic [31:0]           o_wb_data,
    output logic                  o_done
);

    import rv_pkg::*;

    logic [1:0]  lane;
    logic        mem_op;
    logic [31:0] rdata_q;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_ext;

    assign lane   = i_exec.result[1:0];
    assign mem_op = i_dec.is_load | i_dec.is_store;

    always_comb
    begin
        o_req.adr = i_exec.result;
        o_req.we  = i_dec.is_store;
        case (i_dec.funct3[1:0])
            2'b00:   o_req.dat = {4{i_exec.store_data[7:0]}};
            2'b01:   o_req.dat = {2{i_exec.store_data[15:0]}};
            default: o_req.dat = i_exec.store_data;
        endcase
        case (i_dec.funct3[1:0])
            2'b00:   o_req.sel = 4'b0001 << lane;
            2'b01:   o_req.sel = lane[1] ? 4'b1100 : 4'b0011;
            default: o_req.sel = 4'b1111;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            rdata_q <= '0;
        else if (i_mem && i_ack && i_dec.is_load)
            rdata_q <= i_rdata;
    end

    assign ld_byte = rdata_q[8*lane +: 8];
    assign ld_half = lane[1] ? rdata_q[31:16] : rdata_q[15:0];

    always_comb
    begin
        case (i_dec.funct3)
            3'b000:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
            3'b001:  ld_ext = {{16{ld_half[15]}}, ld_half};
            3'b100:  ld_ext = {24'd0, ld_byte};
            3'b101:  ld_ext = {16'd0, ld_half};
            default: ld_ext = rdata_q;
        endcase
    end

    always_comb
    begin
        case (i_dec.res_src)
            res_mem: o_wb_data = ld_ext;
            res_pc4: o_wb_data = i_pc + 32'd4;    // Link address
            res_imm: o_wb_data = i_dec.imm;
            default: o_wb_data = i_exec.result;
        endcase
    end

    assign o_done = i_mem & (mem_op ? i_ack : 1'b1);

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_execute
(
    input  wire  rv_pkg::decode_t i_dec,
    input  wire  [31:0]           i_pc,
    input  wire  [31:0]           i_rs1_data,
    input  wire  [31:0]           i_rs2_data,
    output rv_pkg::exec_t         o_exec
);

    import rv_pkg::*;

    logic [31:0] op1, op2, op2_adj;
    logic        sub_en;
    logic [32:0] sum;
    logic        eq, lts, ltu;
    logic [4:0]  shamt;
    logic [31:0] alu_res;
    logic        cond;
    logic [31:0] br_target;
    logic [31:0] target;

    assign op1 = (i_dec.op1_src == op1_pc)  ? i_pc      : i_rs1_data;
    assign op2 = (i_dec.op2_src == op2_imm) ? i_dec.imm : i_rs2_data;

    // One adder serves add, sub, slt, sltu and branch compares
    assign sub_en  = (i_dec.alu_op == alu_sub) || (i_dec.alu_op == alu_slt) ||
                     (i_dec.alu_op == alu_sltu);
    assign op2_adj = sub_en ? ~op2 : op2;
    assign sum     = {1'b0, op1} + {1'b0, op2_adj} + {32'd0, sub_en};

    assign eq  = (sum[31:0] == 32'd0);
    assign lts = (op1[31] ^ op2[31]) ? op1[31] : sum[31];
    assign ltu = ~sum[32];      // No carry out means borrow

    assign shamt = op2[4:0];

    always_comb
    begin
        case (i_dec.alu_op)
            alu_sll:  alu_res = op1 << shamt;
            alu_slt:  alu_res = {31'd0, lts};
            alu_sltu: alu_res = {31'd0, ltu};
            alu_xor:  alu_res = op1 ^ op2;
            alu_srl:  alu_res = op1 >> shamt;
            alu_sra:  alu_res = $signed(op1) >>> shamt;
            alu_or:   alu_res = op1 | op2;
            alu_and:  alu_res = op1 & op2;
            default:  alu_res = sum[31:0];
        endcase
    end

    always_comb
    begin
        case (i_dec.funct3)
            3'b000:  cond = eq;
            3'b001:  cond = ~eq;
            3'b100:  cond = lts;
            3'b101:  cond = ~lts;
            3'b110:  cond = ltu;
            3'b111:  cond = ~ltu;
            default: cond = 1'b0;
        endcase
    end

    // JAL and JALR targets come from the ALU sum
    assign br_target = i_pc + i_dec.imm;
    assign target    = i_dec.is_branch ? br_target : {sum[31:1], 1'b0};

    always_comb
    begin
        o_exec.result      = alu_res;
        o_exec.store_data  = i_rs2_data;
        o_exec.pc_next     = target;
        o_exec.take_branch = i_dec.is_jal | i_dec.is_jalr | (i_dec.is_branch & cond);
    end

endmodule

`default_nettype wire

// ==== hw/rv_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module rv_regs
(
    input  wire         i_clk,
    input  wire         i_reset_n,
    input  wire  [4:0]  i_rs1,
    input  wire  [4:0]  i_rs2,
    input  wire  [4:0]  i_rd,
    input  wire         i_write,
    input  wire  [31:0] i_data,
    output logic [31:0] o_data1,
    output logic [31:0] o_data2
);

    logic [31:0] regs [`RV_REG_COUNT];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
            o_data1 <= '0;
            o_data2 <= '0;
        end
        else
        begin
            if (i_write && i_rd != 5'd0)
                regs[i_rd] <= i_data;   // x0 stays zero
            o_data1 <= regs[i_rs1];
            o_data2 <= regs[i_rs2];
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module rv_decode
(
    input  wire  rv_pkg::instr_u i_instr,
    input  wire  [31:0]          i_pc,
    output rv_pkg::decode_t      o_dec
);

    import rv_pkg::*;

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [6:0]  opcode;
    alu_op_e     alu_arith;

    assign opcode = i_instr.r_fmt.opcode;

    assign imm_i = {{20{i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
    assign imm_s = {{20{i_instr.s_fmt.imm_11_5[6]}}, i_instr.s_fmt.imm_11_5,
                    i_instr.s_fmt.imm_4_0};
    assign imm_b = {{19{i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_12, i_instr.b_fmt.imm_11,
                    i_instr.b_fmt.imm_10_5, i_instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {i_instr.u_fmt.imm_31_12, 12'd0};
    assign imm_j = {{11{i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_20,
                    i_instr.j_fmt.imm_19_12, i_instr.j_fmt.imm_11,
                    i_instr.j_fmt.imm_10_1, 1'b0};

    // funct7[5] picks sub and sra; OP-IMM has no subi
    always_comb
    begin
        case (i_instr.r_fmt.funct3)
            3'b000:  alu_arith = (opcode == `RV_OP_REG && i_instr.r_fmt.funct7[5]) ?
                                 alu_sub : alu_add;
            3'b001:  alu_arith = alu_sll;
            3'b010:  alu_arith = alu_slt;
            3'b011:  alu_arith = alu_sltu;
            3'b100:  alu_arith = alu_xor;
            3'b101:  alu_arith = i_instr.r_fmt.funct7[5] ? alu_sra : alu_srl;
            3'b110:  alu_arith = alu_or;
            default: alu_arith = alu_and;
        endcase
    end

    always_comb
    begin
        o_dec           = '0;
        o_dec.rs1       = i_instr.r_fmt.rs1;
        o_dec.rs2       = i_instr.r_fmt.rs2;
        o_dec.rd        = i_instr.r_fmt.rd;
        o_dec.funct3    = i_instr.r_fmt.funct3;
        o_dec.alu_op    = alu_add;
        o_dec.op1_src   = op1_rs1;
        o_dec.op2_src   = op2_rs2;
        o_dec.res_src   = res_alu;

        case (opcode)
            `RV_OP_LUI:
            begin
                o_dec.imm       = imm_u;
                o_dec.res_src   = res_imm;
                o_dec.reg_write = 1'b1;
            end
            `RV_OP_AUIPC:
            begin
                o_dec.imm       = i_pc + imm_u;   // Resolved here, PC already known
                o_dec.res_src   = res_imm;
                o_dec.reg_write = 1'b1;
            end
            `RV_OP_JAL:
            begin
                o_dec.imm       = imm_j;
                o_dec.op1_src   = op1_pc;
                o_dec.op2_src   = op2_imm;
                o_dec.res_src   = res_pc4;
                o_dec.reg_write = 1'b1;
                o_dec.is_jal    = 1'b1;
            end
            `RV_OP_JALR:
            begin
                o_dec.imm       = imm_i;
                o_dec.op2_src   = op2_imm;
                o_dec.res_src   = res_pc4;
                o_dec.reg_write = 1'b1;
                o_dec.is_jalr   = 1'b1;
            end
            `RV_OP_BRANCH:
            begin
                o_dec.imm       = imm_b;
                o_dec.alu_op    = alu_sub;        // Compare through the subtractor
                o_dec.is_branch = 1'b1;
            end
            `RV_OP_LOAD:
            begin
                o_dec.imm       = imm_i;
                o_dec.op2_src   = op2_imm;
                o_dec.res_src   = res_mem;
                o_dec.reg_write = 1'b1;
                o_dec.is_load   = 1'b1;
            end
            `RV_OP_STORE:
            begin
                o_dec.imm       = imm_s;
                o_dec.op2_src   = op2_imm;
                o_dec.is_store  = 1'b1;
            end
            `RV_OP_IMM:
            begin
                o_dec.imm       = imm_i;
                o_dec.op2_src   = op2_imm;
                o_dec.alu_op    = alu_arith;
                o_dec.reg_write = 1'b1;
            end
            `RV_OP_REG:
            begin
                o_dec.alu_op    = alu_arith;
                o_dec.reg_write = 1'b1;
            end
            default:
            begin
                o_dec.reg_write = 1'b0;           // FENCE, ECALL and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR = `RV_RESET_ADDR
)
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire                 i_fetch,
    input  wire                 i_ack,
    input  wire  [31:0]         i_rdata,
    input  wire                 i_advance,
    input  wire  rv_pkg::exec_t i_exec,
    output rv_pkg::bus_req_t    o_req,
    output logic [31:0]         o_pc,
    output rv_pkg::instr_u      o_instr
);

    import rv_pkg::*;

    logic [31:0] pc;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (i_advance)
            pc <= i_exec.take_branch ? i_exec.pc_next : pc + 32'd4;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fetch && i_ack)
            o_instr <= i_rdata;     // Word valid in ack cycle
    end

    // Plain word read at the PC
    always_comb
    begin
        o_req.adr = pc;
        o_req.dat = '0;
        o_req.sel = 4'b1111;
        o_req.we  = 1'b0;
    end

    assign o_pc = pc;

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_11_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_4_0;
        logic [6:0]  opcode;
    } s_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // One fetched word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic { op1_rs1, op1_pc } op1_src_e;
    typedef enum logic { op2_rs2, op2_imm } op2_src_e;

    typedef enum logic [1:0] { res_alu, res_mem, res_pc4, res_imm } res_src_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [2:0]  funct3;
        alu_op_e     alu_op;
        op1_src_e    op1_src;
        op2_src_e    op2_src;
        res_src_e    res_src;
        logic        reg_write;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
    } decode_t;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] store_data;
        logic [31:0] pc_next;
        logic        take_branch;
    } exec_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// First fetch address after reset
`define RV_RESET_ADDR   32'h0000_0000

// Architectural register count
`define RV_REG_COUNT    32

// Major opcodes, bits [6:0] of the instruction
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111

`endif
